// File: bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder #(
  parameter int RamAddrBits = 12
) (
  input  logic                                         clk_sys_in,
  input  logic                                         rst_sys_in,
  // host side
  input  logic                                         host_req_i,
  input  logic                                         host_we_i,
  input  logic [periph_pkg::BE_WIDTH-1:0]              host_be_i,
  input  logic [periph_pkg::ADDR_WIDTH-1:0]            host_addr_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0]            host_wdata_i,
  output logic                                         host_rvalid_o,
  output logic [periph_pkg::DATA_WIDTH-1:0]            host_rdata_o,
  output logic                                         host_err_o,
  // device side
  output logic                                         ram_req_o,
  output logic                                         gpio_req_o,
  output logic                                         timer_req_o,
  output logic                                         dev_we_o,
  output logic [periph_pkg::BE_WIDTH-1:0]              dev_be_o,
  output logic [periph_pkg::offset_bits(RamAddrBits)-1:0] dev_offset_o,
  output logic [periph_pkg::DATA_WIDTH-1:0]            dev_wdata_o,
  input  logic [periph_pkg::DATA_WIDTH-1:0]            ram_rdata_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0]            gpio_rdata_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0]            timer_rdata_i
);
  import periph_pkg::*;

  localparam logic [ADDR_WIDTH-1:0] RamSize = 1 << RamAddrBits;
  localparam int OffsetBits = offset_bits(RamAddrBits);

  bus_device_e dev_sel;
  bus_device_e rsp_dev_q;
  logic        rsp_valid_q;
  logic        ram_hit;
  logic        gpio_hit;
  logic        timer_hit;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  assign ram_hit   = (host_addr_i >= RAM_START) && (host_addr_i <= RAM_START + RamSize - 1);
  assign gpio_hit  = (host_addr_i >= GPIO_START)
                  && (host_addr_i <= GPIO_START + DEV_WINDOW_SIZE - 1);
  assign timer_hit = (host_addr_i >= TIMER_START)
                  && (host_addr_i <= TIMER_START + DEV_WINDOW_SIZE - 1);

  always_comb begin
    if (ram_hit) begin
      dev_sel = DEV_RAM;
    end else if (gpio_hit) begin
      dev_sel = DEV_GPIO;
    end else if (timer_hit) begin
      dev_sel = DEV_TIMER;
    end else begin
      dev_sel = DEV_NONE;
    end
  end

  assign ram_req_o   = host_req_i && (dev_sel == DEV_RAM);
  assign gpio_req_o  = host_req_i && (dev_sel == DEV_GPIO);
  assign timer_req_o = host_req_i && (dev_sel == DEV_TIMER);

  assign dev_we_o     = host_we_i;
  assign dev_be_o     = host_be_i;
  assign dev_offset_o = host_addr_i[OffsetBits-1:0];  // bases are window aligned
  assign dev_wdata_o  = host_wdata_i;

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      rsp_valid_q <= 1'b0;
      rsp_dev_q   <= DEV_NONE;
    end else begin
      rsp_valid_q <= host_req_i;  // every request answers next cycle
      if (host_req_i) begin
        rsp_dev_q <= dev_sel;
      end
    end
  end

  always_comb begin
    host_rdata_o = '0;
    if (rsp_valid_q) begin
      case (rsp_dev_q)
        DEV_RAM:   host_rdata_o = ram_rdata_i;
        DEV_GPIO:  host_rdata_o = gpio_rdata_i;
        DEV_TIMER: host_rdata_o = timer_rdata_i;
        default:   host_rdata_o = '0;  // error carries no data
      endcase
    end
  end

  assign host_rvalid_o = rsp_valid_q;
  assign host_err_o    = rsp_valid_q && (rsp_dev_q == DEV_NONE);

  a_dev_onehot: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    $onehot0({ram_req_o, gpio_req_o, timer_req_o}));

  a_err_valid: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    host_err_o |-> host_rvalid_o);

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RamAddrBits = 12
) (
  input  logic                              clk_sys_in,
  input  logic                              rst_sys_in,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [periph_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [RamAddrBits-1:0]            offset_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [periph_pkg::DATA_WIDTH-1:0] rdata_o
);
  import periph_pkg::*;

  localparam int Depth = 2 ** (RamAddrBits - 2);  // 32-bit words

  logic [DATA_WIDTH-1:0]  mem [Depth];
  logic [RamAddrBits-3:0] word_idx;

  assign word_idx = offset_i[RamAddrBits-1:2];  // byte lane bits dropped

  ////////////////////////////////////////
  // write and registered read
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_in) begin
    if (req_i && we_i) begin
      mem[word_idx] <= be_merge(mem[word_idx], wdata_i, be_i);
    end
  end

  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;  // writes answer with zero
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

  // a write that touches no byte is a host bug
  a_write_be: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    req_i && we_i |-> (be_i != '0));

endmodule

// File: filelist.f
periph_pkg.sv
bus_decoder.sv
data_ram.sv
gpio_regs.sv
machine_timer.sv
periph_subsystem.sv
tb_periph_subsystem.sv

// File: gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 8
) (
  input  logic                                    clk_sys_in,
  input  logic                                    rst_sys_in,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [periph_pkg::BE_WIDTH-1:0]         be_i,
  input  logic [periph_pkg::DEV_OFFSET_WIDTH-1:0] offset_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0]       wdata_i,
  input  logic [GpiWidth-1:0]                     gp_i,
  output logic [periph_pkg::DATA_WIDTH-1:0]       rdata_o,
  output logic [GpoWidth-1:0]                     gp_o
);
  import periph_pkg::*;

  logic [GpiWidth-1:0]   gpi_meta_q;
  logic [GpiWidth-1:0]   gpi_sync_q;
  logic [GpoWidth-1:0]   gpo_q;
  logic [DATA_WIDTH-1:0] gpo_ext;
  logic [DATA_WIDTH-1:0] gpi_ext;
  logic [DATA_WIDTH-1:0] gpo_merged;

  assign gpo_ext    = DATA_WIDTH'(gpo_q);  // zero extended
  assign gpi_ext    = DATA_WIDTH'(gpi_sync_q);
  assign gpo_merged = be_merge(gpo_ext, wdata_i, be_i);

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      gpo_q      <= '0;
    end else begin
      gpi_meta_q <= gp_i;  // two stage synchronizer
      gpi_sync_q <= gpi_meta_q;
      if (req_i && we_i && (offset_i == GPIO_OUT_OFFSET)) begin
        gpo_q <= gpo_merged[GpoWidth-1:0];
      end
    end
  end

  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;  // input register is read only
      end else if (offset_i == GPIO_OUT_OFFSET) begin
        rdata_o <= gpo_ext;
      end else if (offset_i == GPIO_IN_OFFSET) begin
        rdata_o <= gpi_ext;
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign gp_o = gpo_q;

endmodule

// File: machine_timer.sv
`timescale 1ns/1ps

module machine_timer (
  input  logic                                    clk_sys_in,
  input  logic                                    rst_sys_in,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [periph_pkg::BE_WIDTH-1:0]         be_i,
  input  logic [periph_pkg::DEV_OFFSET_WIDTH-1:0] offset_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0]       wdata_i,
  output logic [periph_pkg::DATA_WIDTH-1:0]       rdata_o,
  output logic                                    timer_irq_o
);
  import periph_pkg::*;

  localparam int TimeWidth = 2 * DATA_WIDTH;  // 64-bit mtime and mtimecmp

  logic [TimeWidth-1:0] mtime_q;
  logic [TimeWidth-1:0] mtime_d;
  logic [TimeWidth-1:0] mtimecmp_q;
  logic [TimeWidth-1:0] mtimecmp_d;
  logic                 irq_q;

  ////////////////////////////////////////
  // counter and compare next state
  ////////////////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + 1'b1;  // free running
    mtimecmp_d = mtimecmp_q;
    if (req_i && we_i) begin
      case (offset_i)
        TIMER_MTIME_LO: begin
          mtime_d = {mtime_q[TimeWidth-1:DATA_WIDTH],
                     be_merge(mtime_q[DATA_WIDTH-1:0], wdata_i, be_i)};
        end
        TIMER_MTIME_HI: begin
          mtime_d = {be_merge(mtime_q[TimeWidth-1:DATA_WIDTH], wdata_i, be_i),
                     mtime_q[DATA_WIDTH-1:0]};
        end
        TIMER_CMP_LO: begin
          mtimecmp_d = {mtimecmp_q[TimeWidth-1:DATA_WIDTH],
                        be_merge(mtimecmp_q[DATA_WIDTH-1:0], wdata_i, be_i)};
        end
        TIMER_CMP_HI: begin
          mtimecmp_d = {be_merge(mtimecmp_q[TimeWidth-1:DATA_WIDTH], wdata_i, be_i),
                        mtimecmp_q[DATA_WIDTH-1:0]};
        end
        default: ;  // unused offsets ignore writes
      endcase
    end
  end

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // no interrupt until software sets a compare
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);  // one cycle behind the match
    end
  end

  ////////////////////////////////////////
  // register read
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_in) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        case (offset_i)
          TIMER_MTIME_LO: rdata_o <= mtime_q[DATA_WIDTH-1:0];
          TIMER_MTIME_HI: rdata_o <= mtime_q[TimeWidth-1:DATA_WIDTH];
          TIMER_CMP_LO:   rdata_o <= mtimecmp_q[DATA_WIDTH-1:0];
          TIMER_CMP_HI:   rdata_o <= mtimecmp_q[TimeWidth-1:DATA_WIDTH];
          default:        rdata_o <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = irq_q;

endmodule

// File: periph_pkg.sv
package periph_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  localparam int ADDR_WIDTH       = 32;
  localparam int DATA_WIDTH       = 32;
  localparam int BE_WIDTH         = DATA_WIDTH / 8;
  localparam int DEV_OFFSET_WIDTH = 12;  // 4 KiB device windows

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  localparam logic [ADDR_WIDTH-1:0] RAM_START       = 32'h0020_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_START      = 32'h8000_0000;
  localparam logic [ADDR_WIDTH-1:0] TIMER_START     = 32'h8000_2000;
  localparam logic [ADDR_WIDTH-1:0] DEV_WINDOW_SIZE = 32'd4096;  // gpio and timer

  typedef enum logic [1:0] {
    DEV_RAM   = 2'd0,
    DEV_GPIO  = 2'd1,
    DEV_TIMER = 2'd2,
    DEV_NONE  = 2'd3  // unmapped, answered with an error
  } bus_device_e;

  // gpio registers
  localparam logic [DEV_OFFSET_WIDTH-1:0] GPIO_OUT_OFFSET = 12'h000;
  localparam logic [DEV_OFFSET_WIDTH-1:0] GPIO_IN_OFFSET  = 12'h004;

  // timer registers
  localparam logic [DEV_OFFSET_WIDTH-1:0] TIMER_MTIME_LO = 12'h000;
  localparam logic [DEV_OFFSET_WIDTH-1:0] TIMER_MTIME_HI = 12'h004;
  localparam logic [DEV_OFFSET_WIDTH-1:0] TIMER_CMP_LO   = 12'h008;
  localparam logic [DEV_OFFSET_WIDTH-1:0] TIMER_CMP_HI   = 12'h00C;

  // shared offset bus must cover both the ram and the device windows
  function automatic int offset_bits(int ram_addr_bits);
    return (ram_addr_bits > DEV_OFFSET_WIDTH) ? ram_addr_bits : DEV_OFFSET_WIDTH;
  endfunction

  // replaces the enabled byte lanes of old_data
  function automatic logic [DATA_WIDTH-1:0] be_merge(
    logic [DATA_WIDTH-1:0] old_data,
    logic [DATA_WIDTH-1:0] new_data,
    logic [BE_WIDTH-1:0]   be
  );
    logic [DATA_WIDTH-1:0] merged;
    merged = old_data;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_data[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: periph_subsystem.sv
`timescale 1ns/1ps

module periph_subsystem #(
  parameter int RamAddrBits = 12,
  parameter int GpiWidth    = 8,
  parameter int GpoWidth    = 8
) (
  input  logic                              clk_sys_in,
  input  logic                              rst_sys_in,
  // host port, core data bus
  input  logic                              host_req_i,
  input  logic                              host_we_i,
  input  logic [periph_pkg::BE_WIDTH-1:0]   host_be_i,
  input  logic [periph_pkg::ADDR_WIDTH-1:0] host_addr_i,
  input  logic [periph_pkg::DATA_WIDTH-1:0] host_wdata_i,
  output logic                              host_rvalid_o,
  output logic [periph_pkg::DATA_WIDTH-1:0] host_rdata_o,
  output logic                              host_err_o,
  // pins and interrupt
  input  logic [GpiWidth-1:0]               gp_i,
  output logic [GpoWidth-1:0]               gp_o,
  output logic                              timer_irq_o
);
  import periph_pkg::*;

  localparam int OffsetBits = offset_bits(RamAddrBits);

  logic                  ram_req;
  logic                  gpio_req;
  logic                  timer_req;
  logic                  dev_we;
  logic [BE_WIDTH-1:0]   dev_be;
  logic [OffsetBits-1:0] dev_offset;
  logic [DATA_WIDTH-1:0] dev_wdata;
  logic [DATA_WIDTH-1:0] ram_rdata;
  logic [DATA_WIDTH-1:0] gpio_rdata;
  logic [DATA_WIDTH-1:0] timer_rdata;

  ////////////////////////////////////////
  // decoder
  ////////////////////////////////////////

  bus_decoder #(
    .RamAddrBits(RamAddrBits)
  ) u_bus_decoder (
    .clk_sys_in   (clk_sys_in),
    .rst_sys_in   (rst_sys_in),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_offset_o (dev_offset),
    .dev_wdata_o  (dev_wdata),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  ////////////////////////////////////////
  // devices
  ////////////////////////////////////////

  data_ram #(
    .RamAddrBits(RamAddrBits)
  ) u_data_ram (
    .clk_sys_in(clk_sys_in),
    .rst_sys_in(rst_sys_in),
    .req_i     (ram_req),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .offset_i  (dev_offset[RamAddrBits-1:0]),
    .wdata_i   (dev_wdata),
    .rdata_o   (ram_rdata)
  );

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio_regs (
    .clk_sys_in(clk_sys_in),
    .rst_sys_in(rst_sys_in),
    .req_i     (gpio_req),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .offset_i  (dev_offset[DEV_OFFSET_WIDTH-1:0]),
    .wdata_i   (dev_wdata),
    .gp_i      (gp_i),
    .rdata_o   (gpio_rdata),
    .gp_o      (gp_o)
  );

  machine_timer u_machine_timer (
    .clk_sys_in (clk_sys_in),
    .rst_sys_in (rst_sys_in),
    .req_i      (timer_req),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .offset_i   (dev_offset[DEV_OFFSET_WIDTH-1:0]),
    .wdata_i    (dev_wdata),
    .rdata_o    (timer_rdata),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_subsystem \
  -f filelist.f -o sim_periph > sim.log 2>&1 \
  && ./obj_dir/sim_periph >> sim.log 2>&1
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb_periph_subsystem.sv
`timescale 1ns/1ps

module tb_periph_subsystem;
  import periph_pkg::*;

  localparam int RamAddrBits  = 12;
  localparam int GpioWidth    = 8;
  localparam int TimerGap     = 10;
  localparam int TimeoutLimit = 3000;  // the tests need about 150 cycles

  logic                  clk_sys_in;
  logic                  rst_sys_in;
  logic                  host_req;
  logic                  host_we;
  logic [BE_WIDTH-1:0]   host_be;
  logic [ADDR_WIDTH-1:0] host_addr;
  logic [DATA_WIDTH-1:0] host_wdata;
  logic                  host_rvalid;
  logic [DATA_WIDTH-1:0] host_rdata;
  logic                  host_err;
  logic [GpioWidth-1:0]  gp_in;
  logic [GpioWidth-1:0]  gp_out;
  logic                  timer_irq;
  logic [31:0]           lfsr_q;
  int                    error_count = 0;
  int                    check_count = 0;
  int                    cycle_count = 0;

  periph_subsystem #(
    .RamAddrBits(RamAddrBits),
    .GpiWidth   (GpioWidth),
    .GpoWidth   (GpioWidth)
  ) UUT (
    .clk_sys_in   (clk_sys_in),
    .rst_sys_in   (rst_sys_in),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  always #20 clk_sys_in = ~clk_sys_in;  // 40 ns period

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      w[i]   = lfsr_q[0];
    end
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk_sys_in);
      #2;
    end
  endtask

  // called 2 ns after an edge, returns 2 ns after the next one
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    host_req   = 1'b1;
    host_we    = we;
    host_be    = be;
    host_addr  = addr;
    host_wdata = wdata;
    @(posedge clk_sys_in);
    #2;
    if (!host_rvalid) begin
      error_count++;
      $display("no response one cycle after the request to address 0x%08h", addr);
    end
    rdata    = host_rdata;
    err      = host_err;
    host_req = 1'b0;  // a following access raises it again at once
  endtask

  task automatic bus_write(string name, logic [31:0] addr, logic [31:0] data, logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, be, addr, data, rdata, err);
    check_value({name, " write err"}, 32'd0, {31'd0, err});
    check_value({name, " write data"}, 32'd0, rdata);
  endtask

  task automatic bus_read(string name, logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_access(1'b0, 4'hF, addr, 32'd0, data, err);
    check_value({name, " read err"}, 32'd0, {31'd0, err});
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_values();
    check_value("reset gp_o", 32'd0, 32'(gp_out));
    check_value("reset timer_irq_o", 32'd0, 32'(timer_irq));
    check_value("reset host_rvalid_o", 32'd0, 32'(host_rvalid));
  endtask

  task automatic test_ram_round_trip();
    logic [31:0] model [16];
    logic [31:0] rdata;
    for (int i = 0; i < 16; i++) begin
      next_word(model[i]);
      bus_write("ram_round_trip", RAM_START + 32'(4 * i), model[i], 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read("ram_round_trip", RAM_START + 32'(4 * i), rdata);
      check_value("ram_round_trip", model[i], rdata);
    end
  endtask

  task automatic test_ram_byte_enables();
    logic [31:0] full;
    logic [31:0] b0;
    logic [31:0] b2;
    logic [31:0] rdata;
    next_word(full);
    next_word(b0);
    next_word(b2);
    bus_write("ram_byte_enables", RAM_START + 32'h100, full, 4'b1111);
    bus_write("ram_byte_enables", RAM_START + 32'h100, b0, 4'b0001);
    bus_write("ram_byte_enables", RAM_START + 32'h100, b2, 4'b0100);
    bus_read("ram_byte_enables", RAM_START + 32'h100, rdata);
    check_value("ram_byte_enables", {full[31:24], b2[23:16], full[15:8], b0[7:0]}, rdata);
  endtask

  task automatic test_gpio();
    logic [31:0] rdata;
    bus_write("gpio_out", GPIO_START + GPIO_OUT_OFFSET, 32'h0000_00A5, 4'hF);
    check_value("gpio_out pins", 32'h0000_00A5, 32'(gp_out));
    bus_read("gpio_out", GPIO_START + GPIO_OUT_OFFSET, rdata);
    check_value("gpio_out readback", 32'h0000_00A5, rdata);
    gp_in = 8'h3C;
    idle_cycles(2);  // two synchronizer stages
    bus_read("gpio_in", GPIO_START + GPIO_IN_OFFSET, rdata);
    check_value("gpio_in readback", 32'h0000_003C, rdata);
    bus_write("gpio_in", GPIO_START + GPIO_IN_OFFSET, 32'h0000_00FF, 4'hF);
    bus_read("gpio_in", GPIO_START + GPIO_IN_OFFSET, rdata);
    check_value("gpio_in after write", 32'h0000_003C, rdata);
    check_value("gpio_out after in write", 32'h0000_00A5, 32'(gp_out));
  endtask

  task automatic test_timer();
    logic [31:0] t_first;
    logic [31:0] t_second;
    logic [31:0] now;
    int          wait_count;
    bus_read("timer_count", TIMER_START + TIMER_MTIME_LO, t_first);
    idle_cycles(TimerGap - 1);
    bus_read("timer_count", TIMER_START + TIMER_MTIME_LO, t_second);
    check_value("timer_count", TimerGap, t_second - t_first);
    bus_read("timer_irq", TIMER_START + TIMER_MTIME_LO, now);
    bus_write("timer_irq", TIMER_START + TIMER_CMP_HI, 32'd0, 4'hF);
    bus_write("timer_irq", TIMER_START + TIMER_CMP_LO, now + 32'd20, 4'hF);
    check_value("timer_irq early", 32'd0, 32'(timer_irq));
    wait_count = 0;
    while (!timer_irq && wait_count < 40) begin
      idle_cycles(1);
      wait_count++;
    end
    if (!timer_irq) begin
      error_count++;
      $display("timer interrupt did not rise within 40 cycles of the compare write");
    end
    bus_write("timer_clear", TIMER_START + TIMER_CMP_HI, 32'hFFFF_FFFF, 4'hF);
    bus_write("timer_clear", TIMER_START + TIMER_CMP_LO, 32'hFFFF_FFFF, 4'hF);
    idle_cycles(1);
    check_value("timer_irq clear", 32'd0, 32'(timer_irq));
  endtask

  task automatic test_unmapped(logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, 4'hF, addr, 32'd0, rdata, err);
    check_value("unmapped read err", 32'd1, {31'd0, err});
    check_value("unmapped read data", 32'd0, rdata);
    bus_access(1'b1, 4'hF, addr, 32'hDEAD_BEEF, rdata, err);
    check_value("unmapped write err", 32'd1, {31'd0, err});
    check_value("unmapped write data", 32'd0, rdata);
  endtask

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial begin
    clk_sys_in = 1'b0;
    rst_sys_in = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_be    = '0;
    host_addr  = '0;
    host_wdata = '0;
    gp_in      = '0;
    lfsr_q     = 32'h6c110419;
    repeat (2) @(posedge clk_sys_in);
    #2;
    rst_sys_in = 1'b1;
    test_reset_values();
    test_ram_round_trip();
    test_ram_byte_enables();
    test_gpio();
    test_timer();
    test_unmapped(32'h0000_0000);
    test_unmapped(RAM_START + 32'(1 << RamAddrBits));  // one past the ram window
    test_unmapped(32'h8000_3000);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TimeoutLimit) begin
      @(posedge clk_sys_in);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
